//--- bench/mips_core_sva.sv
// Decode-stage assertions on hold, redirect squash and the stall bubble, bound into every decode_stage
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_sva
(
	input logic                  clk,
	input logic                  rst,
	input logic                  hold,
	input logic                  redirect,
	input logic [`CORE_XLEN-1:0] inst,
	input logic                  wb_en
);

	// Load-use stall is a single cycle
	hold_single_cycle: assert property (@(posedge clk) disable iff (rst) hold |=> !hold)
		else $error("Decode hold stayed high for two cycles");

	// Taken branch or jump leaves a NOP in decode
	squash_after_redirect: assert property (@(posedge clk) disable iff (rst)
		redirect |=> (inst == `CORE_NOP))
		else $error("Decode did not receive a squashed NOP after redirect");

	// Bubble from the stalled cycle reaches writeback empty
	bubble_after_hold: assert property (@(posedge clk) disable iff (rst)
		hold |=> ##1 !wb_en)
		else $error("Writeback fired for the bubble that followed hold");

endmodule

bind decode_stage decode_sva u_decode_sva
(
	.clk      (clk),
	.rst      (rst),
	.hold     (hold),
	.redirect (redirect),
	.inst     (inst),
	.wb_en    (wb_en)
);

//--- bench/mips_core_tb.sv
// Random-program testbench for the core, run against an instruction-level model of the ISA
`timescale 1ns/1ps
`include "core_cfg.svh"

module mips_core_tb;
	import core_pkg::*;

	localparam int PROG_LEN  = 200;
	localparam int MEM_WORDS = 256;
	// Watchdog limit in cycles after reset
	localparam int TIMEOUT_CYCLES = PROG_LEN * 3 + 100;

	// DUT ports
	logic        clk;
	logic        rst;
	logic [31:0] imem_data;
	logic [31:0] imem_addr;
	logic        wb_en;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic        stall;
	logic        exception;

	// Program image, NOP past the end
	logic [31:0] imem [MEM_WORDS];

	// Expected results from the model
	logic [4:0]  exp_reg [$];
	logic [31:0] exp_val [$];
	int exp_stalls = 0;
	int exp_exc    = 0;

	// Observed counts
	int wb_seen    = 0;
	int stall_seen = 0;
	int exc_seen   = 0;
	int err_count  = 0;

	logic [31:0] seed = 32'h17764891;

	mips_core DUT
	(
		.clk       (clk),
		.rst       (rst),
		.imem_data (imem_data),
		.imem_addr (imem_addr),
		.wb_en     (wb_en),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.stall     (stall),
		.exception (exception)
	);

	// --------------------
	// Helpers
	// --------------------

	// LCG, upper half used
	function automatic int unsigned rand_below(input int unsigned n);
		seed = seed * 32'd1664525 + 32'd1013904223;
		return (seed >> 16) % n;
	endfunction

	// Source register that avoids the previous ALU result
	function automatic logic [4:0] pick_src(input logic [4:0] busy);
		logic [4:0] r;
		r = 5'(rand_below(8));
		if (busy != 5'd0 && r == busy)
			r = r ^ 5'd1;
		return r;
	endfunction

	function automatic funct_e pick_funct();
		case (rand_below(5))
			0:       return FN_ADD;
			1:       return FN_SUB;
			2:       return FN_AND;
			3:       return FN_OR;
			default: return FN_SLT;
		endcase
	endfunction

	function automatic logic [31:0] i_word(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
		err_count++;
	endtask

	// --------------------
	// Program generator
	// --------------------
	task automatic build_program();
		logic [4:0]  last_dst;
		logic [4:0]  d;
		logic [15:0] imm;
		logic [15:0] addr;
		int          kind;
		last_dst = 5'd0;
		for (int w = 0; w < MEM_WORDS; w++)
			imem[w] = `CORE_NOP;
		for (int i = 0; i < PROG_LEN; i++)
		begin
			kind = rand_below(16);
			d    = 5'(rand_below(8));
			imm  = 16'(rand_below(65536));
			addr = 16'(4 * rand_below(`CORE_DMEM_WORDS));
			case (kind)
				0, 1, 2, 3:
					imem[i] = {OP_R, pick_src(last_dst), pick_src(last_dst), d, 5'd0, pick_funct()};
				4, 5:
					imem[i] = i_word(OP_ADDI, pick_src(last_dst), d, imm);
				6:
					imem[i] = i_word(OP_ADDIU, pick_src(last_dst), d, imm);
				7:
					imem[i] = i_word(OP_ANDI, pick_src(last_dst), d, imm);
				// Memory ops use r0 as base so addresses stay in range
				8, 9:
					imem[i] = i_word(OP_LW, 5'd0, d, addr);
				10, 11:
					imem[i] = i_word(OP_SW, 5'd0, pick_src(last_dst), addr);
				// Forward branches only
				12, 13:
					imem[i] = i_word((kind == 12) ? OP_BEQ : OP_BNE, pick_src(last_dst),
						pick_src(last_dst), 16'(1 + rand_below(4)));
				14:
					imem[i] = {OP_J, 26'(i + 2 + rand_below(4))};
				default:
					imem[i] = {6'h3f, 5'(rand_below(8)), 5'(rand_below(8)), imm};
			endcase
			// Only ALU results lack a hardware interlock
			last_dst = (kind <= 7) ? d : 5'd0;
		end
	endtask

	// --------------------
	// Reference model
	// --------------------
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] dmem [`CORE_DMEM_WORDS];
		logic [31:0] w;
		logic [31:0] nxt;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] v;
		logic [4:0]  dst;
		int          idx;
		int          pc;
		int          pc_next;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		for (int m = 0; m < `CORE_DMEM_WORDS; m++)
			dmem[m] = '0;
		pc = 0;
		while (pc < PROG_LEN)
		begin
			w       = imem[pc];
			nxt     = imem[pc + 1];
			a       = regs[w[25:21]];
			b       = regs[w[20:16]];
			sx      = {{16{w[15]}}, w[15:0]};
			idx     = ((a + sx) >> 2) % `CORE_DMEM_WORDS;
			dst     = 5'd0;
			pc_next = pc + 1;
			case (w[31:26])
				OP_R:
				begin
					dst = w[15:11];
					case (w[5:0])
						FN_ADD:  v = a + b;
						FN_SUB:  v = a - b;
						FN_AND:  v = a & b;
						FN_OR:   v = a | b;
						default: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					endcase
				end
				OP_ADDI, OP_ADDIU:
				begin
					dst = w[20:16];
					v   = a + sx;
				end
				OP_ANDI:
				begin
					dst = w[20:16];
					v   = a & {16'h0000, w[15:0]};
				end
				OP_LW:
				begin
					dst = w[20:16];
					v   = dmem[idx];
					// Next word naming the load target in rs or rt stalls once
					if (dst != 5'd0 && (nxt[25:21] == dst || nxt[20:16] == dst))
						exp_stalls++;
				end
				OP_SW:
					dmem[idx] = b;
				OP_BEQ:
					if (a == b)
						pc_next = pc + 1 + w[15:0];
				OP_BNE:
					if (a != b)
						pc_next = pc + 1 + w[15:0];
				OP_J:
					pc_next = w[25:0];
				default:
					exp_exc++;
			endcase
			if (dst != 5'd0)
			begin
				regs[dst] = v;
				exp_reg.push_back(dst);
				exp_val.push_back(v);
			end
			pc = pc_next;
		end
	endtask

	// --------------------
	// Clock, memory and monitor
	// --------------------
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Instruction word for the current PC, ready before the next edge
	always @(negedge clk)
		imem_data <= imem[imem_addr[9:2]];

	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (stall)
				stall_seen++;
			if (exception)
				exc_seen++;
			if (wb_en)
			begin
				if (wb_seen >= exp_reg.size())
				begin
					$display("Extra writeback at %0t to r%0d beyond the expected sequence",
						$time, wb_reg);
					err_count++;
				end
				else
				begin
					if (wb_reg !== exp_reg[wb_seen])
						report_mismatch("wb_reg", exp_reg[wb_seen], wb_reg);
					if (wb_data !== exp_val[wb_seen])
						report_mismatch("wb_data", exp_val[wb_seen], wb_data);
				end
				wb_seen++;
			end
		end
	end

	// Watchdog
	initial
	begin
		repeat (16 + TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		rst       = 1'b1;
		imem_data = `CORE_NOP;
		build_program();
		run_model();
		repeat (16) @(negedge clk);
		// Reset state
		if (wb_en !== 1'b0)
			report_mismatch("wb_en", 32'd0, wb_en);
		if (stall !== 1'b0)
			report_mismatch("stall", 32'd0, stall);
		if (exception !== 1'b0)
			report_mismatch("exception", 32'd0, exception);
		if (imem_addr !== 32'd0)
			report_mismatch("imem_addr", 32'd0, imem_addr);
		rst <= 1'b0;
		// Run until the PC leaves the program, then drain the pipeline
		while (imem_addr < 4 * PROG_LEN)
			@(negedge clk);
		repeat (5) @(negedge clk);
		#1;
		if (wb_seen != exp_reg.size())
			report_mismatch("writeback count", exp_reg.size(), wb_seen);
		if (stall_seen != exp_stalls)
			report_mismatch("stall cycles", exp_stalls, stall_seen);
		if (exc_seen != exp_exc)
			report_mismatch("exception pulses", exp_exc, exc_seen);
		$display("Summary: %0d writebacks, %0d stalls, %0d exceptions, %0d errors",
			wb_seen, stall_seen, exc_seen, err_count);
		if (err_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- hw/core_cfg.svh
// Width and size macros for the core that every RTL file includes where it needs them
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and address width
`define CORE_XLEN 32

// Architectural registers
`define CORE_NREGS 32

// Data memory depth in words
`define CORE_DMEM_WORDS 64

// All-zero word used for squash and bubble
`define CORE_NOP 32'h0000_0000

`endif

//--- hw/core_pkg.sv
// Shared encodings and control-field structs that the stages import by wildcard
package core_pkg;

	// Primary opcodes in inst[31:26]
	typedef enum logic [5:0]
	{
		OP_R     = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_ANDI  = 6'b001100,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_e;

	// R-type function codes in inst[5:0]
	typedef enum logic [5:0]
	{
		FN_ADD = 6'b100000,
		FN_SUB = 6'b100010,
		FN_AND = 6'b100100,
		FN_OR  = 6'b100101,
		FN_SLT = 6'b101010
	} funct_e;

	// ALU operation, add is the zero code
	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4
	} alu_op_e;

	// Execute controls
	typedef struct packed
	{
		logic    alu_src;
		alu_op_e alu_op;
		logic    reg_dst;
	} ex_ctrl_t;

	// Memory controls
	typedef struct packed
	{
		logic branch;
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	// Writeback controls
	typedef struct packed
	{
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

endpackage

//--- hw/decode_stage.sv
// Decode stage with control, register file, load-use hazard, branch resolve and ID/EX register
`timescale 1ns/1ps
`include "core_cfg.svh"

module decode_stage
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`CORE_XLEN-1:0] inst,
	input  logic [`CORE_XLEN-1:0] inst_pc,
	input  logic                  wb_en,
	input  logic [4:0]            wb_reg,
	input  logic [`CORE_XLEN-1:0] wb_data,
	input  logic                  ex_load,
	input  logic [4:0]            ex_rt,
	output logic                  hold,
	output logic                  redirect,
	output logic [`CORE_XLEN-1:0] target,
	output logic                  exception,
	id_ex_if.source               id_ex
);
	import core_pkg::*;

	// Instruction fields
	opcode_e               opcode;
	funct_e                funct;
	logic [4:0]            rs;
	logic [4:0]            rt;
	logic [4:0]            rd;
	logic [15:0]           imm16;
	logic [25:0]           jidx;
	logic [`CORE_XLEN-1:0] imm;

	// Decoded controls
	ex_ctrl_t  ctrl_ex;
	mem_ctrl_t ctrl_m;
	wb_ctrl_t  ctrl_wb;
	logic      illegal;
	logic      is_jump;

	// Register file storage and read ports
	logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
	logic [`CORE_XLEN-1:0] rd_data_1;
	logic [`CORE_XLEN-1:0] rd_data_2;

	// Branch resolve
	logic [`CORE_XLEN-1:0] pc_plus4;
	logic                  taken;

	assign opcode = opcode_e'(inst[31:26]);
	assign funct  = funct_e'(inst[5:0]);
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign imm16  = inst[15:0];
	assign jidx   = inst[25:0];

	// ANDI takes a zero-extended immediate
	assign imm = (opcode == OP_ANDI) ? {{(`CORE_XLEN-16){1'b0}}, imm16}
		: {{(`CORE_XLEN-16){imm16[15]}}, imm16};

	// --------------------
	// Control unit
	// --------------------
	always_comb
	begin
		ctrl_ex = '0;
		ctrl_m  = '0;
		ctrl_wb = '0;
		illegal = 1'b0;
		is_jump = 1'b0;
		case (opcode)
			OP_R:
			begin
				ctrl_ex.reg_dst   = 1'b1;
				ctrl_wb.reg_write = 1'b1;
				// Unlisted funct falls back to add
				case (funct)
					FN_ADD:  ctrl_ex.alu_op = ALU_ADD;
					FN_SUB:  ctrl_ex.alu_op = ALU_SUB;
					FN_AND:  ctrl_ex.alu_op = ALU_AND;
					FN_OR:   ctrl_ex.alu_op = ALU_OR;
					FN_SLT:  ctrl_ex.alu_op = ALU_SLT;
					default: ctrl_ex.alu_op = ALU_ADD;
				endcase
			end
			OP_ADDI, OP_ADDIU:
			begin
				ctrl_ex.alu_src   = 1'b1;
				ctrl_wb.reg_write = 1'b1;
			end
			OP_ANDI:
			begin
				ctrl_ex.alu_src   = 1'b1;
				ctrl_ex.alu_op    = ALU_AND;
				ctrl_wb.reg_write = 1'b1;
			end
			OP_BEQ, OP_BNE:
			begin
				ctrl_ex.alu_op = ALU_SUB;
				ctrl_m.branch  = 1'b1;
			end
			OP_J:
				is_jump = 1'b1;
			OP_LW:
			begin
				ctrl_ex.alu_src    = 1'b1;
				ctrl_m.mem_read    = 1'b1;
				ctrl_wb.reg_write  = 1'b1;
				ctrl_wb.mem_to_reg = 1'b1;
			end
			OP_SW:
			begin
				ctrl_ex.alu_src  = 1'b1;
				ctrl_m.mem_write = 1'b1;
			end
			// Unknown opcode runs as a no-op
			default:
				illegal = 1'b1;
		endcase
	end

	// Suppressed while stalled so it pulses once
	assign exception = illegal && !hold;

	// --------------------
	// Register file
	// --------------------

	// R0 reads zero, same-cycle write bypasses to the read
	function automatic logic [`CORE_XLEN-1:0] reg_read(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		else if (wb_en && wb_reg == addr)
			return wb_data;
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rd_data_1 = reg_read(rs);
		rd_data_2 = reg_read(rt);
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < `CORE_NREGS; i++)
				regs[i] <= '0;
		end
		else if (wb_en && wb_reg != 5'd0)
			regs[wb_reg] <= wb_data;
	end

	// Load in execute feeding this instruction
	assign hold = ex_load && (ex_rt != 5'd0) && (ex_rt == rs || ex_rt == rt);

	// --------------------
	// Branch and jump
	// --------------------
	assign pc_plus4 = inst_pc + 'd4;

	always_comb
	begin
		taken = 1'b0;
		if (ctrl_m.branch)
			taken = (opcode == OP_BNE) ? (rd_data_1 != rd_data_2) : (rd_data_1 == rd_data_2);
	end

	// Jump keeps the top four bits of PC+4
	assign target = is_jump ? {pc_plus4[`CORE_XLEN-1:28], jidx, 2'b00}
		: pc_plus4 + {imm[`CORE_XLEN-3:0], 2'b00};

	// No redirect while the stalled word waits
	assign redirect = !hold && (taken || is_jump);

	// --------------------
	// ID/EX register
	// --------------------

	// Controls become a bubble on hold
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			id_ex.ex <= '0;
			id_ex.m  <= '0;
			id_ex.wb <= '0;
		end
		else
		begin
			id_ex.ex <= hold ? '0 : ctrl_ex;
			id_ex.m  <= hold ? '0 : ctrl_m;
			id_ex.wb <= hold ? '0 : ctrl_wb;
		end
	end

	// Operands and register numbers
	always_ff @(posedge clk)
	begin
		id_ex.data_1 <= rd_data_1;
		id_ex.data_2 <= rd_data_2;
		id_ex.imm    <= imm;
		id_ex.rt     <= rt;
		id_ex.dst    <= ctrl_ex.reg_dst ? rd : rt;
	end

endmodule

//--- hw/execute_stage.sv
// Execute stage with ALU, word data memory and the writeback register that feeds decode
`timescale 1ns/1ps
`include "core_cfg.svh"

module execute_stage
(
	input  logic                  clk,
	input  logic                  rst,
	id_ex_if.sink                 id_ex,
	output logic                  ex_load,
	output logic [4:0]            ex_rt,
	output logic                  wb_en,
	output logic [4:0]            wb_reg,
	output logic [`CORE_XLEN-1:0] wb_data
);
	import core_pkg::*;

	// Word address bits
	localparam int AW = $clog2(`CORE_DMEM_WORDS);

	// ALU path
	logic [`CORE_XLEN-1:0] alu_b;
	logic [`CORE_XLEN-1:0] alu_res;

	// Memory path
	logic [AW-1:0]         word_addr;
	logic [`CORE_XLEN-1:0] load_data;
	logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS];

	// Value headed for writeback
	logic [`CORE_XLEN-1:0] result;

	// To the hazard unit
	assign ex_load = id_ex.m.mem_read;
	assign ex_rt   = id_ex.rt;

	// --------------------
	// ALU
	// --------------------
	assign alu_b = id_ex.ex.alu_src ? id_ex.imm : id_ex.data_2;

	always_comb
	begin
		case (id_ex.ex.alu_op)
			ALU_ADD: alu_res = id_ex.data_1 + alu_b;
			ALU_SUB: alu_res = id_ex.data_1 - alu_b;
			ALU_AND: alu_res = id_ex.data_1 & alu_b;
			ALU_OR:  alu_res = id_ex.data_1 | alu_b;
			// Signed compare
			ALU_SLT: alu_res = {{(`CORE_XLEN-1){1'b0}},
				$signed(id_ex.data_1) < $signed(alu_b)};
			default: alu_res = '0;
		endcase
	end

	// --------------------
	// Data memory
	// --------------------

	// Byte address to word index, upper bits ignored
	assign word_addr = alu_res[AW+1:2];

	// Combinational load
	assign load_data = dmem[word_addr];

	// Store lands at the end of the execute cycle
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < `CORE_DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (id_ex.m.mem_write)
			dmem[word_addr] <= id_ex.data_2;
	end

	// --------------------
	// Writeback register
	// --------------------
	assign result = id_ex.wb.mem_to_reg ? load_data : alu_res;

	// Writes to R0 never leave the stage
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			wb_en <= 1'b0;
		else
			wb_en <= id_ex.wb.reg_write && (id_ex.dst != 5'd0);
	end

	always_ff @(posedge clk)
	begin
		wb_reg  <= id_ex.dst;
		wb_data <= result;
	end

endmodule

//--- hw/fetch_stage.sv
// Fetch stage that holds the PC and the fetch/decode register and obeys hold and redirect
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_stage
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  hold,
	input  logic                  redirect,
	input  logic [`CORE_XLEN-1:0] target,
	input  logic [`CORE_XLEN-1:0] imem_data,
	output logic [`CORE_XLEN-1:0] imem_addr,
	output logic [`CORE_XLEN-1:0] inst,
	output logic [`CORE_XLEN-1:0] inst_pc
);

	// Current fetch address
	logic [`CORE_XLEN-1:0] pc;

	// Instruction memory reads combinationally from the PC
	assign imem_addr = pc;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pc      <= '0;
			inst    <= `CORE_NOP;
			inst_pc <= '0;
		end
		else if (redirect)
		begin
			// Jump to target and squash the word fetched this cycle
			pc      <= target;
			inst    <= `CORE_NOP;
			inst_pc <= pc;
		end
		else if (!hold)
		begin
			pc      <= pc + 'd4;
			inst    <= imem_data;
			inst_pc <= pc;
		end
		// Hold keeps PC and decode word
	end

endmodule

//--- hw/id_ex_if.sv
// Decoded instruction bundle from decode to execute that the core top instantiates once
`timescale 1ns/1ps
`include "core_cfg.svh"

interface id_ex_if;
	import core_pkg::*;

	// Control groups, all zero for a bubble
	ex_ctrl_t  ex;
	mem_ctrl_t m;
	wb_ctrl_t  wb;

	// Operands read in decode
	logic [`CORE_XLEN-1:0] data_1;
	logic [`CORE_XLEN-1:0] data_2;

	// Extended immediate
	logic [`CORE_XLEN-1:0] imm;

	// Load target for the hazard check
	logic [4:0] rt;

	// Destination after reg_dst
	logic [4:0] dst;

	// Decode side writes the register
	modport source
	(
		output ex, m, wb, data_1, data_2, imm, rt, dst
	);

	// Execute side reads it
	modport sink
	(
		input ex, m, wb, data_1, data_2, imm, rt, dst
	);

endinterface

//--- hw/mips_core.sv
// Core top that wires fetch, decode and execute to an outside instruction memory
`timescale 1ns/1ps
`include "core_cfg.svh"

module mips_core
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`CORE_XLEN-1:0] imem_data,
	output logic [`CORE_XLEN-1:0] imem_addr,
	output logic                  wb_en,
	output logic [4:0]            wb_reg,
	output logic [`CORE_XLEN-1:0] wb_data,
	output logic                  stall,
	output logic                  exception
);

	// Fetch to decode
	logic [`CORE_XLEN-1:0] inst;
	logic [`CORE_XLEN-1:0] inst_pc;

	// Decode to fetch
	logic                  redirect;
	logic [`CORE_XLEN-1:0] target;

	// Execute to the hazard unit
	logic                  ex_load;
	logic [4:0]            ex_rt;

	// Decode/execute bundle
	id_ex_if id_ex ();

	fetch_stage u_fetch
	(
		.clk       (clk),
		.rst       (rst),
		.hold      (stall),
		.redirect  (redirect),
		.target    (target),
		.imem_data (imem_data),
		.imem_addr (imem_addr),
		.inst      (inst),
		.inst_pc   (inst_pc)
	);

	// Hold leaves the core as stall
	decode_stage u_decode
	(
		.clk       (clk),
		.rst       (rst),
		.inst      (inst),
		.inst_pc   (inst_pc),
		.wb_en     (wb_en),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.ex_load   (ex_load),
		.ex_rt     (ex_rt),
		.hold      (stall),
		.redirect  (redirect),
		.target    (target),
		.exception (exception),
		.id_ex     (id_ex.source)
	);

	// Writeback port also feeds the register file
	execute_stage u_execute
	(
		.clk     (clk),
		.rst     (rst),
		.id_ex   (id_ex.sink),
		.ex_load (ex_load),
		.ex_rt   (ex_rt),
		.wb_en   (wb_en),
		.wb_reg  (wb_reg),
		.wb_data (wb_data)
	);

endmodule

//--- list.f
+incdir+hw
hw/core_pkg.sv
hw/id_ex_if.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mips_core.sv
bench/mips_core_sva.sv
bench/mips_core_tb.sv
